// ==== verilog.f ====
+incdir+logic
logic/play_pkg.sv
logic/play_fsm.sv
logic/beat_timer.sv
logic/note_buffer.sv
logic/score_unit.sv
logic/led_driver.sv
logic/play_chart_top.sv
verification/play_checker.sv
verification/play_chart_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= play_chart_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/play_chart_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "play_defines.svh"

module play_chart_tb
    import play_pkg::*;
;

    localparam int NUM_TESTS = 7;
    localparam int MAX_NOTES = 12;
    localparam int LIMIT = (4 * `COUNT_TICKS + MAX_NOTES * `NOTE_TICKS + 50) * NUM_TESTS;

    logic                prog_clk;
    logic                rst;
    logic                note_valid;
    note_t               note_data;
    logic                note_last;
    logic [6:0]          note_keys;
    logic                oct_up;
    logic                oct_down;
    logic                auto_play;
    logic                free_play;
    logic                exit_key;
    logic                note_credit;
    logic [1:0]          countdown;
    logic                playing;
    logic                finished;
    logic                exited;
    logic [7:0]          led;
    logic [`SCORE_W-1:0] score;
    logic [`SCORE_W-1:0] max_score;
    rank_t               rank;

    note_t chart[$];
    note_t keys[$];
    int    sent;
    int    credits_back;
    int    errors = 0;
    int    cycle_count = 0;
    int    tests = 0;
    int    failed = 0;
    int    errors_before;
    string cur_test;

    play_chart_top dut0 (.*);

    play_checker chk0 (
        .prog_clk(prog_clk), .rst(rst), .note_valid(note_valid), .note_data(note_data),
        .note_keys(note_keys), .oct_up(oct_up), .oct_down(oct_down),
        .auto_play(auto_play), .free_play(free_play), .note_credit(note_credit),
        .led(led), .score(score), .max_score(max_score), .rank(rank)
    );

    always #5 prog_clk = ~prog_clk;

    always @(posedge prog_clk) begin
        cycle_count++;
        if (cycle_count >= LIMIT) begin
            $display("Timeout: the run did not complete within %0d cycles", LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    // Counts returned credits and watches the sender's balance
    always @(negedge prog_clk) begin
        if (rst) begin
            credits_back = 0;
        end else if (note_credit) begin
            credits_back++;
            if (`NOTE_BUF_DEPTH - sent + credits_back > `NOTE_BUF_DEPTH) begin
                $display("[%s] more credits returned than notes sent", cur_test);
                errors++;
            end
        end
        if (`NOTE_BUF_DEPTH - sent + credits_back < 0) begin
            $display("[%s] sender credit count went negative", cur_test);
            errors++;
        end
    end

    task automatic check(input string what, input int exp, input int act);
        if (exp != act) begin
            $display("** Error [%s] %s: expected %0d, actual %0d", cur_test, what, exp, act);
            errors++;
        end
    endtask

    function automatic note_t mk(input int idx, input logic up, input logic down);
        note_t n;
        n = '0;
        if (idx >= 0) begin
            n.pitch = 7'(1) << idx;
            n.up    = up;
            n.down  = down;
        end
        return n;
    endfunction

    task automatic apply_keys(input int i);
        if (i < keys.size()) begin
            note_keys = keys[i].pitch;
            oct_up    = keys[i].up;
            oct_down  = keys[i].down;
        end else begin
            note_keys = 7'd0;
            oct_up    = 1'b0;
            oct_down  = 1'b0;
        end
    endtask

    task automatic begin_test(input string name, input logic auto_m, input logic free_m);
        cur_test = name;
        chk0.start_test(name);
        errors_before = errors + chk0.errors;
        auto_play = auto_m;
        free_play = free_m;
        exit_key  = 1'b0;
        sent      = 0;
        apply_keys(0);
        rst = 1'b1;
        repeat (5) @(posedge prog_clk);
        #1;
        rst = 1'b0;
    endtask

    task automatic end_test();
        int errs;
        repeat (3) @(posedge prog_clk);
        #1;
        errs = errors + chk0.errors - errors_before;
        tests++;
        if (errs != 0) begin
            failed++;
            $display("Test %s: %0d errors", cur_test, errs);
        end else begin
            $display("Test %s: ok", cur_test);
        end
        chart.delete();
        keys.delete();
    endtask

    // Sends the chart under credit control and may pause before note pause_at
    task automatic run_chart(input int pause_at);
        int    seen;
        int    held_score;
        int    held_led;
        int    held_back;
        seen = 0;
        apply_keys(0);
        while (!finished) begin
            @(posedge prog_clk);
            #1;
            note_valid = 1'b0;
            note_last  = 1'b0;
            if (credits_back != seen) begin
                seen = credits_back;
                apply_keys(seen);
            end
            if (sent == pause_at && credits_back == sent) begin
                held_score = int'(score);
                held_led   = int'(led);
                held_back  = credits_back;
                repeat (3 * `NOTE_TICKS) begin
                    @(posedge prog_clk);
                    #1;
                    check("score during underrun", held_score, int'(score));
                    check("led during underrun", held_led, int'(led));
                    check("credits during underrun", held_back, credits_back);
                end
                pause_at = -1;
            end
            if (`NOTE_BUF_DEPTH - sent + credits_back > 0 && sent < chart.size()
                    && sent != pause_at) begin
                note_valid = 1'b1;
                note_data  = chart[sent];
                note_last  = (sent == chart.size() - 1);
                sent++;
            end
        end
        note_valid = 1'b0;
        note_last  = 1'b0;
        // The last credit returns in the cycle finished rises
        check("credit with finish", 1, int'(note_credit));
        @(posedge prog_clk);
        #1;
        check("credits returned", sent, credits_back);
    endtask

    initial begin
        int n;
        int last_cd;
        int r;
        prog_clk   = 1'b0;
        rst        = 1'b1;
        note_valid = 1'b0;
        note_data  = '0;
        note_last  = 1'b0;
        note_keys  = 7'd0;
        oct_up     = 1'b0;
        oct_down   = 1'b0;
        auto_play  = 1'b0;
        free_play  = 1'b0;
        exit_key   = 1'b0;
        void'($urandom(32'h61b5a54f));

        begin_test("reset_countdown", 1'b0, 1'b0);
        check("countdown", 3, int'(countdown));
        check("playing", 0, int'(playing));
        check("finished", 0, int'(finished));
        check("exited", 0, int'(exited));
        check("note_credit", 0, int'(note_credit));
        check("led", 0, int'(led));
        check("score", 0, int'(score));
        check("max_score", 0, int'(max_score));
        check("rank", int'(RANK_NONE), int'(rank));
        n = 0;
        last_cd = 3;
        do begin
            @(posedge prog_clk);
            #1;
            n++;
            if (int'(countdown) != last_cd) begin
                check("countdown step", last_cd - 1, int'(countdown));
                last_cd = int'(countdown);
            end
        end while (!playing && n < 200);
        check("cycles to playing", 4 * `COUNT_TICKS, n);
        check("last digit", 0, last_cd);
        end_test();

        begin_test("credit_flow", 1'b0, 1'b0);
        for (int i = 0; i < MAX_NOTES; i++) begin
            r = int'($urandom % 32'd8) - 1;
            chart.push_back(mk(r, $urandom % 2 == 0, 1'b0));
        end
        run_chart(-1);
        end_test();

        begin_test("manual_scoring", 1'b0, 1'b0);
        chart = '{mk(0, 0, 0), mk(1, 0, 0), mk(2, 0, 0), mk(3, 0, 0),
                  mk(4, 0, 0), mk(3, 1, 0), mk(-1, 0, 0), mk(6, 0, 1)};
        // Exact, wrong, late by one, shifted, wrong, late by two, rest, exact
        keys  = '{mk(0, 0, 0), mk(2, 0, 0), mk(-1, 0, 0), mk(3, 1, 0),
                  mk(5, 0, 0), mk(6, 0, 0), mk(-1, 0, 0), mk(6, 0, 1)};
        run_chart(-1);
        end_test();

        begin_test("auto_play", 1'b1, 1'b0);
        chart = '{mk(0, 0, 0), mk(-1, 0, 0), mk(4, 1, 0), mk(2, 0, 1), mk(-1, 0, 0)};
        run_chart(-1);
        check("final score", 3 * `PTS_AUTO, int'(score));
        end_test();

        begin_test("free_play", 1'b0, 1'b1);
        chart = '{mk(1, 0, 0), mk(5, 0, 0), mk(3, 1, 0)};
        keys  = '{mk(1, 0, 0), mk(5, 0, 0), mk(3, 1, 0)};
        run_chart(-1);
        check("rank", int'(RANK_NONE), int'(rank));
        end_test();

        begin_test("underrun", 1'b0, 1'b0);
        for (int i = 0; i < 8; i++) begin
            chart.push_back(mk(i % 7, 1'b0, 1'b0));
            keys.push_back(mk(i % 7, 1'b0, 1'b0));
        end
        run_chart(5);
        end_test();

        begin_test("finish_exit", 1'b0, 1'b0);
        chart = '{mk(2, 0, 0), mk(0, 0, 1), mk(6, 0, 0)};
        run_chart(-1);
        repeat (10) begin
            @(posedge prog_clk);
            #1;
            check("finished held", 1, int'(finished));
            check("playing after finish", 0, int'(playing));
        end
        exit_key = 1'b1;
        @(posedge prog_clk);
        #1;
        exit_key = 1'b0;
        check("exited", 1, int'(exited));
        check("playing after exit", 0, int'(playing));
        check("finished after exit", 0, int'(finished));
        end_test();

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests, failed,
                 errors + chk0.errors);
        if (failed == 0 && errors + chk0.errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/play_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "play_defines.svh"

module play_checker
    import play_pkg::*;
(
    input logic                prog_clk,
    input logic                rst,
    input logic                note_valid,
    input note_t               note_data,
    input logic [6:0]          note_keys,
    input logic                oct_up,
    input logic                oct_down,
    input logic                auto_play,
    input logic                free_play,
    input logic                note_credit,
    input logic [7:0]          led,
    input logic [`SCORE_W-1:0] score,
    input logic [`SCORE_W-1:0] max_score,
    input rank_t               rank
);

    typedef struct packed {
        logic [7:0] led;
        logic [7:0] d_score;
        logic [7:0] d_max;
    } expect_t;

    note_t   sent_q[$];
    note_t   hist0;
    note_t   hist1;
    note_t   keys;
    note_t   cur;
    expect_t exp_v;
    int      exp_score;
    int      exp_max;
    int      errors = 0;
    string   test_name = "none";

    task automatic start_test(input string name);
        test_name = name;
    endtask

    // Expected increments and LED pattern for one stepped note
    function automatic expect_t ref_step(input note_t n, input note_t k, input note_t h0,
                                         input note_t h1, input logic auto_m, input logic free_m);
        expect_t e;
        e = '0;
        e.led[0] = n.up | n.down;
        for (int j = 1; j < 8; j++) begin
            e.led[j] = n.pitch[7-j];
        end
        if (!free_m && n.pitch != 7'd0) begin
            e.d_max = 8'(`PTS_MAX);
            if (auto_m) begin
                e.d_score = 8'(`PTS_AUTO);
            end else if (n == k) begin
                e.d_score = 8'(`PTS_EXACT);
            end else if (n == h0) begin
                e.d_score = 8'(`PTS_LATE1);
            end else if (n == h1) begin
                e.d_score = 8'(`PTS_LATE2);
            end
        end
        return e;
    endfunction

    function automatic rank_t ref_rank(input int s, input int m);
        int pct;
        if (m == 0) begin
            return RANK_NONE;
        end
        pct = 100 * s / m;
        if (pct >= 90) return RANK_S;
        if (pct >= 80) return RANK_A;
        if (pct >= 70) return RANK_B;
        if (pct >= 60) return RANK_C;
        return RANK_D;
    endfunction

    task automatic check(input string what, input int exp, input int act);
        if (exp != act) begin
            $display("** Error [%s] %s: expected %0d, actual %0d", test_name, what, exp, act);
            errors++;
        end
    endtask

    // Sender stream and DUT outputs are both stable at the falling edge
    always @(negedge prog_clk) begin
        if (rst) begin
            sent_q.delete();
            hist0     = '0;
            hist1     = '0;
            exp_score = 0;
            exp_max   = 0;
        end else begin
            if (note_credit) begin
                if (sent_q.size() == 0) begin
                    $display("[%s] credit pulse with no note outstanding", test_name);
                    errors++;
                end else begin
                    cur   = sent_q.pop_front();
                    keys  = '{down: oct_down, up: oct_up, pitch: note_keys};
                    exp_v = ref_step(cur, keys, hist0, hist1, auto_play, free_play);
                    exp_score += int'(exp_v.d_score);
                    exp_max   += int'(exp_v.d_max);
                    if (!auto_play && !free_play && keys.pitch != 7'd0) begin
                        hist1 = hist0;
                        hist0 = keys;
                    end
                    check("led", int'(exp_v.led), int'(led));
                    check("score", exp_score, int'(score));
                    check("max_score", exp_max, int'(max_score));
                    check("rank", int'(ref_rank(exp_score, exp_max)), int'(rank));
                end
            end
            if (note_valid) begin
                sent_q.push_back(note_data);
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/play_chart_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "play_defines.svh"

module play_chart_top
    import play_pkg::*;
(
    input  logic                prog_clk,
    input  logic                rst,
    input  logic                note_valid,
    input  note_t               note_data,
    input  logic                note_last,
    input  logic [6:0]          note_keys,
    input  logic                oct_up,
    input  logic                oct_down,
    input  logic                auto_play,
    input  logic                free_play,
    input  logic                exit_key,
    output logic                note_credit,
    output logic [1:0]          countdown,
    output logic                playing,
    output logic                finished,
    output logic                exited,
    output logic [7:0]          led,
    output logic [`SCORE_W-1:0] score,
    output logic [`SCORE_W-1:0] max_score,
    output rank_t               rank
);

    play_state_t play_state;
    logic        count_done;
    logic        note_step;
    logic        pop;
    note_t       head_note;
    logic        head_last;

    play_fsm fsm0 (
        .prog_clk   (prog_clk),
        .rst        (rst),
        .count_done (count_done),
        .pop        (pop),
        .head_last  (head_last),
        .exit_key   (exit_key),
        .play_state (play_state)
    );

    beat_timer timer0 (
        .prog_clk   (prog_clk),
        .rst        (rst),
        .play_state (play_state),
        .countdown  (countdown),
        .count_done (count_done),
        .note_step  (note_step)
    );

    note_buffer buf0 (
        .prog_clk    (prog_clk),
        .rst         (rst),
        .note_valid  (note_valid),
        .note_data   (note_data),
        .note_last   (note_last),
        .note_step   (note_step),
        .pop         (pop),
        .head_note   (head_note),
        .head_last   (head_last),
        .note_credit (note_credit)
    );

    score_unit score0 (
        .prog_clk  (prog_clk),
        .rst       (rst),
        .pop       (pop),
        .head_note (head_note),
        .note_keys (note_keys),
        .oct_up    (oct_up),
        .oct_down  (oct_down),
        .auto_play (auto_play),
        .free_play (free_play),
        .score     (score),
        .max_score (max_score),
        .rank      (rank)
    );

    led_driver led0 (
        .prog_clk  (prog_clk),
        .rst       (rst),
        .pop       (pop),
        .head_note (head_note),
        .led       (led)
    );

    // Status decodes
    assign playing  = (play_state == PLAYING);
    assign finished = (play_state == FINISHED);
    assign exited   = (play_state == EXITED);

endmodule

`default_nettype wire

// ==== logic/led_driver.sv ====
`timescale 1ns/1ns
`default_nettype none

module led_driver
    import play_pkg::*;
(
    input  logic       prog_clk,
    input  logic       rst,
    input  logic       pop,
    input  note_t      head_note,
    output logic [7:0] led
);

    logic [6:0] pitch_mirror;

    // C on the leftmost LED and B next to the octave LED
    always_comb begin
        for (int i = 0; i < 7; i++) begin
            pitch_mirror[6-i] = head_note.pitch[i];
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            led <= 8'd0;
        end else if (pop) begin
            led <= {pitch_mirror, head_note.up | head_note.down};
        end
    end

endmodule

`default_nettype wire

// ==== logic/score_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "play_defines.svh"

module score_unit
    import play_pkg::*;
(
    input  logic                prog_clk,
    input  logic                rst,
    input  logic                pop,
    input  note_t               head_note,
    input  logic [6:0]          note_keys,
    input  logic                oct_up,
    input  logic                oct_down,
    input  logic                auto_play,
    input  logic                free_play,
    output logic [`SCORE_W-1:0] score,
    output logic [`SCORE_W-1:0] max_score,
    output rank_t               rank
);

    localparam int PCT_W = `SCORE_W + 7;

    note_t               cur_in;
    note_t               hist0;
    note_t               hist1;
    logic                scored;
    logic                key_held;
    logic [`SCORE_W-1:0] gain;
    logic [PCT_W-1:0]    score_x100;
    logic [PCT_W-1:0]    max_w;

    assign cur_in   = '{down: oct_down, up: oct_up, pitch: note_keys};
    assign key_held = (note_keys != 7'd0);
    assign scored   = pop && !free_play && (head_note.pitch != 7'd0);

    // Best match among this step and the two previous keyed steps
    always_comb begin
        if (auto_play) begin
            gain = `SCORE_W'(`PTS_AUTO);
        end else if (head_note == cur_in) begin
            gain = `SCORE_W'(`PTS_EXACT);
        end else if (head_note == hist0) begin
            gain = `SCORE_W'(`PTS_LATE1);
        end else if (head_note == hist1) begin
            gain = `SCORE_W'(`PTS_LATE2);
        end else begin
            gain = '0;
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            score     <= '0;
            max_score <= '0;
            hist0     <= '0;
            hist1     <= '0;
        end else begin
            if (scored) begin
                max_score <= max_score + `SCORE_W'(`PTS_MAX);
                score     <= score + gain;
            end
            // History only advances on manual pops with a key down
            if (pop && !auto_play && !free_play && key_held) begin
                hist0 <= cur_in;
                hist1 <= hist0;
            end
        end
    end

    // 100*score/max >= N is the same as 100*score >= N*max
    assign score_x100 = PCT_W'(score) * PCT_W'(100);
    assign max_w      = PCT_W'(max_score);

    always_comb begin
        if (max_score == '0) begin
            rank = RANK_NONE;
        end else if (score_x100 >= max_w * PCT_W'(90)) begin
            rank = RANK_S;
        end else if (score_x100 >= max_w * PCT_W'(80)) begin
            rank = RANK_A;
        end else if (score_x100 >= max_w * PCT_W'(70)) begin
            rank = RANK_B;
        end else if (score_x100 >= max_w * PCT_W'(60)) begin
            rank = RANK_C;
        end else begin
            rank = RANK_D;
        end
    end

endmodule

`default_nettype wire

// ==== logic/note_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "play_defines.svh"

module note_buffer
    import play_pkg::*;
(
    input  logic  prog_clk,
    input  logic  rst,
    input  logic  note_valid,
    input  note_t note_data,
    input  logic  note_last,
    input  logic  note_step,
    output logic  pop,
    output note_t head_note,
    output logic  head_last,
    output logic  note_credit
);

    localparam int DEPTH = `NOTE_BUF_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    note_t             mem_note [DEPTH];
    logic              mem_last [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;

    // A missed step with an empty buffer is simply lost
    assign pop       = note_step && (count != '0);
    assign head_note = mem_note[rd_ptr];
    assign head_last = mem_last[rd_ptr];

    always_ff @(posedge prog_clk) begin
        if (note_valid) begin
            mem_note[wr_ptr] <= note_data;
            mem_last[wr_ptr] <= note_last;
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            note_credit <= 1'b0;
        end else begin
            note_credit <= pop;
            if (note_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Credits keep the sender from writing into a full buffer
            case ({note_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/beat_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "play_defines.svh"

module beat_timer
    import play_pkg::*;
(
    input  logic        prog_clk,
    input  logic        rst,
    input  play_state_t play_state,
    output logic [1:0]  countdown,
    output logic        count_done,
    output logic        note_step
);

    localparam int MAX_TICKS = (`COUNT_TICKS > `NOTE_TICKS) ? `COUNT_TICKS : `NOTE_TICKS;
    localparam int TICK_W    = (MAX_TICKS > 1) ? $clog2(MAX_TICKS) : 1;

    logic [TICK_W-1:0] tick;
    logic              digit_wrap;

    assign digit_wrap = (play_state == COUNTDOWN) && (tick == TICK_W'(`COUNT_TICKS - 1));
    assign count_done = digit_wrap && (countdown == 2'd0);
    assign note_step  = (play_state == PLAYING) && (tick == TICK_W'(`NOTE_TICKS - 1));

    // One counter serves both phases and restarts from 0 when play begins
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            tick      <= '0;
            countdown <= 2'd3;
        end else if (digit_wrap || note_step) begin
            tick <= '0;
            if (digit_wrap && countdown != 2'd0) begin
                countdown <= countdown - 2'd1;
            end
        end else if (play_state == COUNTDOWN || play_state == PLAYING) begin
            tick <= tick + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/play_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module play_fsm
    import play_pkg::*;
(
    input  logic        prog_clk,
    input  logic        rst,
    input  logic        count_done,
    input  logic        pop,
    input  logic        head_last,
    input  logic        exit_key,
    output play_state_t play_state
);

    play_state_t next_state;

    always_comb begin
        next_state = play_state;
        case (play_state)
            COUNTDOWN: begin
                if (count_done) begin
                    next_state = PLAYING;
                end
            end
            PLAYING: begin
                // Exit wins over the last pop
                if (exit_key) begin
                    next_state = EXITED;
                end else if (pop && head_last) begin
                    next_state = FINISHED;
                end
            end
            FINISHED: begin
                if (exit_key) begin
                    next_state = EXITED;
                end
            end
            // Only reset leaves here
            default: next_state = EXITED;
        endcase
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            play_state <= COUNTDOWN;
        end else begin
            play_state <= next_state;
        end
    end

endmodule

`default_nettype wire

// ==== logic/play_pkg.sv ====
`default_nettype none

package play_pkg;

    // Octave shift bits above a one-hot pitch with C in bit 0
    // All zero is a rest
    typedef struct packed {
        logic       down;
        logic       up;
        logic [6:0] pitch;
    } note_t;

    typedef enum logic [1:0] {
        COUNTDOWN,
        PLAYING,
        FINISHED,
        EXITED
    } play_state_t;

    typedef enum logic [2:0] {
        RANK_NONE,
        RANK_S,
        RANK_A,
        RANK_B,
        RANK_C,
        RANK_D
    } rank_t;

endpackage

`default_nettype wire

// ==== logic/play_defines.svh ====
`ifndef PLAY_DEFINES_SVH
`define PLAY_DEFINES_SVH

// Clock cycles per countdown digit
`define COUNT_TICKS 8

// Clock cycles per note step
`define NOTE_TICKS 6

// Note buffer entries and the sender's initial credits
`define NOTE_BUF_DEPTH 4

// Score points
`define PTS_MAX 5
`define PTS_EXACT 5
`define PTS_LATE1 3
`define PTS_LATE2 2
`define PTS_AUTO 4

`define SCORE_W 14

`endif
